//--- sources.f
verilog/mmu_pkg.sv
verilog/csr_pkg.sv
verilog/mmu_csr_regs.sv
verilog/tlb_array.sv
verilog/mmu_lane.sv
verilog/fault_recorder.sv
verilog/mmu_top.sv
sim/tb_mmu.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_mmu
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_mmu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mmu;

	import mmu_pkg::*;
	import csr_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int REQ_CYCLES = 150;
	localparam int PHASES = 6;
	localparam int DRAIN_CYCLES = 10;

	typedef struct packed {
		logic [31:0] vaddr;
		logic [31:0] paddr;
		logic [MAT_W-1:0] mat;
		ecode_e ecode;
		logic [31:0] due;
	} resp_t;

	logic clk = 1'b0;
	logic reset_i;
	logic csr_we_i;
	csr_addr_e csr_addr_i;
	logic [31:0] csr_wdata_i;
	logic tlb_wr_i;
	logic [PORT_NUM-1:0] req_valid_i;
	logic [PORT_NUM-1:0][VADDR_W-1:0] req_vaddr_i;
	access_e [PORT_NUM-1:0] req_access_i;
	logic [PORT_NUM-1:0] resp_valid_o;
	logic [PORT_NUM-1:0][VADDR_W-1:0] resp_paddr_o;
	logic [PORT_NUM-1:0][MAT_W-1:0] resp_mat_o;
	ecode_e [PORT_NUM-1:0] resp_ecode_o;
	logic fault_o;
	logic [VADDR_W-1:0] badv_o;
	ecode_e ecode_o;

	int seed = 32'hb7f1;
	logic [31:0] cycle_cnt = '0;
	logic checking = 1'b0;

	// model state
	logic [1:0] m_plv;
	logic m_da;
	logic [1:0] m_datf, m_datm;
	logic [31:0] m_dmw0, m_dmw1, m_lo0, m_lo1;
	logic [9:0] m_asid;
	logic [18:0] m_vppn;
	logic [2:0] m_idx;
	logic [7:0] t_e, t_g;
	logic [9:0] t_asid [8];
	logic [18:0] t_vppn [8];
	logic [31:0] t_lo0 [8];
	logic [31:0] t_lo1 [8];
	resp_t q0[$];
	resp_t q1[$];
	logic f_pend;
	logic [31:0] f_badv;
	ecode_e f_ecode;

	mmu_top i_dut (
		.clk(clk), .reset_i(reset_i),
		.csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
		.tlb_wr_i(tlb_wr_i),
		.req_valid_i(req_valid_i), .req_vaddr_i(req_vaddr_i), .req_access_i(req_access_i),
		.resp_valid_o(resp_valid_o), .resp_paddr_o(resp_paddr_o),
		.resp_mat_o(resp_mat_o), .resp_ecode_o(resp_ecode_o),
		.fault_o(fault_o), .badv_o(badv_o), .ecode_o(ecode_o)
	);

	always #HALF_PERIOD clk = ~clk;

	always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_paddr(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_mat(input string name, input logic [MAT_W-1:0] got,
		input logic [MAT_W-1:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_ecode(input string name, input ecode_e got, input ecode_e exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("error %s got %h expected %h", name, got, exp));
		end
	endtask

	// translation rules as the architecture gives them
	task automatic translate(input logic [31:0] va, input access_e acc,
		output logic [31:0] pa, output logic [MAT_W-1:0] mat, output ecode_e ec);
		logic [31:0] lo;
		int hit;
		ec = ECODE_NONE;
		hit = -1;
		if (m_da) begin
			pa = va;
			mat = (acc == ACC_FETCH) ? m_datf : m_datm;
		end else if (((m_dmw0[0] && m_plv == 0) || (m_dmw0[3] && m_plv == 3))
			&& m_dmw0[31:29] == va[31:29]) begin
			pa = {m_dmw0[27:25], va[28:0]};
			mat = m_dmw0[5:4];
		end else if (((m_dmw1[0] && m_plv == 0) || (m_dmw1[3] && m_plv == 3))
			&& m_dmw1[31:29] == va[31:29]) begin
			pa = {m_dmw1[27:25], va[28:0]};
			mat = m_dmw1[5:4];
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (hit < 0 && t_e[i] && t_vppn[i] == va[31:13] && (t_g[i] || t_asid[i] == m_asid))
					hit = i;
			end
			lo = (hit < 0) ? '0 : (va[12] ? t_lo1[hit] : t_lo0[hit]);
			pa = {lo[27:8], va[11:0]};
			mat = lo[5:4];
			if (hit < 0)
				ec = ECODE_TLBR;
			else if (!lo[0])
				ec = (acc == ACC_FETCH) ? ECODE_PIF : (acc == ACC_LOAD) ? ECODE_PIL : ECODE_PIS;
			else if (m_plv > lo[3:2])
				ec = ECODE_PPI;
			else if (acc == ACC_STORE && !lo[1])
				ec = ECODE_PME;
		end
		if (ec != ECODE_NONE) begin
			pa = '0;
			mat = '0;
		end
	endtask

	task automatic write_csr(input csr_addr_e addr, input logic [31:0] data);
		@(negedge clk);
		req_valid_i = '0;
		csr_we_i = 1'b1;
		csr_addr_i = addr;
		csr_wdata_i = data;
		case (addr)
			CSR_CRMD: begin
				m_plv = data[1:0];
				m_da = data[3];
				m_datf = data[6:5];
				m_datm = data[8:7];
			end
			CSR_ASID: m_asid = data[9:0];
			CSR_TLBIDX: m_idx = data[2:0];
			CSR_TLBEHI: m_vppn = data[31:13];
			CSR_TLBELO0: m_lo0 = data;
			CSR_TLBELO1: m_lo1 = data;
			CSR_DMW0: m_dmw0 = data;
			default: m_dmw1 = data;
		endcase
		@(negedge clk);
		csr_we_i = 1'b0;
	endtask

	task automatic fill_entry(input logic [2:0] idx);
		write_csr(CSR_TLBIDX, {29'd0, idx});
		write_csr(CSR_TLBEHI, $random(seed));
		// small asid range so that asid matches happen
		write_csr(CSR_ASID, $unsigned($random(seed)) % 4);
		write_csr(CSR_TLBELO0, $random(seed) | 32'h1);
		write_csr(CSR_TLBELO1, $random(seed));
		@(negedge clk);
		tlb_wr_i = 1'b1;
		t_e[m_idx] = 1'b1;
		t_g[m_idx] = m_lo0[6] & m_lo1[6];
		t_asid[m_idx] = m_asid;
		t_vppn[m_idx] = m_vppn;
		t_lo0[m_idx] = m_lo0;
		t_lo1[m_idx] = m_lo1;
		@(negedge clk);
		tlb_wr_i = 1'b0;
	endtask

	function automatic logic [31:0] pick_vaddr();
		logic [31:0] r;
		int sel;
		r = $random(seed);
		sel = $unsigned($random(seed)) % 4;
		if (sel == 1)
			r[31:29] = r[0] ? m_dmw0[31:29] : m_dmw1[31:29];
		else if (sel >= 2)
			r[31:13] = t_vppn[$unsigned($random(seed)) % 8];
		return r;
	endfunction

	task automatic run_requests(input int n);
		resp_t item;
		logic [31:0] pa;
		logic [MAT_W-1:0] mat;
		ecode_e ec;
		for (int c = 0; c < n; c++) begin
			@(negedge clk);
			for (int p = 0; p < PORT_NUM; p++) begin
				req_valid_i[p] = ($unsigned($random(seed)) % 4) != 0;
				req_vaddr_i[p] = pick_vaddr();
				req_access_i[p] = (p == 0) ? ACC_FETCH : access_e'(1 + ($unsigned($random(seed)) % 2));
				if (req_valid_i[p]) begin
					translate(req_vaddr_i[p], req_access_i[p], pa, mat, ec);
					item = '{vaddr: req_vaddr_i[p], paddr: pa, mat: mat, ecode: ec,
						due: cycle_cnt + 1};
					if (p == 0)
						q0.push_back(item);
					else
						q1.push_back(item);
				end
			end
		end
		@(negedge clk);
		req_valid_i = '0;
	endtask

	task automatic check_port(input int p, inout resp_t q[$], inout logic pend,
		inout logic [31:0] badv, inout ecode_e fec);
		resp_t item;
		logic exp_valid;
		exp_valid = q.size() != 0 && q[0].due == cycle_cnt;
		check_bit($sformatf("resp_valid_o[%0d]", p), resp_valid_o[p], exp_valid);
		if (exp_valid) begin
			item = q.pop_front();
			check_paddr($sformatf("resp_paddr_o[%0d]", p), resp_paddr_o[p], item.paddr);
			check_mat($sformatf("resp_mat_o[%0d]", p), resp_mat_o[p], item.mat);
			check_ecode($sformatf("resp_ecode_o[%0d]", p), resp_ecode_o[p], item.ecode);
			if (item.ecode != ECODE_NONE) begin
				pend = 1'b1;
				badv = item.vaddr;
				fec = item.ecode;
			end
		end
	endtask

	// responses and fault record sampled mid-cycle
	always @(negedge clk) begin
		logic pend;
		if (checking) begin
			check_bit("fault_o", fault_o, f_pend);
			check_paddr("badv_o", badv_o, f_badv);
			check_ecode("ecode_o", ecode_o, f_ecode);
			pend = 1'b0;
			// port 1 checked last so it overrides port 0
			check_port(0, q0, pend, f_badv, f_ecode);
			check_port(1, q1, pend, f_badv, f_ecode);
			f_pend = pend;
		end
	end

	initial begin
		reset_i = 1'b1;
		csr_we_i = 1'b0;
		csr_addr_i = CSR_CRMD;
		csr_wdata_i = '0;
		tlb_wr_i = 1'b0;
		req_valid_i = '0;
		req_vaddr_i = '0;
		req_access_i = {ACC_LOAD, ACC_FETCH};
		m_plv = '0;
		m_da = 1'b1;
		m_datf = '0;
		m_datm = '0;
		m_dmw0 = '0;
		m_dmw1 = '0;
		m_lo0 = '0;
		m_lo1 = '0;
		m_asid = '0;
		m_vppn = '0;
		m_idx = '0;
		t_e = '0;
		t_g = '0;
		for (int i = 0; i < 8; i++) begin
			t_asid[i] = '0;
			t_vppn[i] = '0;
			t_lo0[i] = '0;
			t_lo1[i] = '0;
		end
		f_pend = 1'b0;
		f_badv = '0;
		f_ecode = ECODE_NONE;
		repeat (5) @(negedge clk);
		reset_i = 1'b0;
		checking = 1'b1;
		repeat (3) @(negedge clk);

		// direct mode with random datf and datm
		write_csr(CSR_CRMD, 32'h8 | ($unsigned($random(seed)) & 32'h1e0));
		run_requests(REQ_CYCLES / 3);

		for (int i = 0; i < 8; i++)
			fill_entry(i[2:0]);

		for (int ph = 0; ph < PHASES; ph++) begin
			write_csr(CSR_DMW0, $random(seed));
			if (ph % 3 == 1)
				write_csr(CSR_DMW1, {m_dmw0[31:29], 29'($random(seed))});
			else
				write_csr(CSR_DMW1, $random(seed));
			if (ph > 1)
				fill_entry(3'($random(seed)));
			write_csr(CSR_ASID, $unsigned($random(seed)) % 4);
			// paged mode with plv 3 on odd phases
			write_csr(CSR_CRMD, 32'h10 | ((ph % 2) ? 32'h3 : 32'h0));
			run_requests(REQ_CYCLES);
		end

		for (int i = 0; i < DRAIN_CYCLES && (q0.size() != 0 || q1.size() != 0); i++)
			@(negedge clk);
		repeat (2) @(negedge clk);
		if (q0.size() != 0 || q1.size() != 0) begin
			$display("timeout while waiting for the last responses");
			$display("TEST RESULT: FAIL");
			$fatal(1, "run stopped");
		end else begin
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mmu_top.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_top (
	input  logic                                               clk,
	input  logic                                               reset_i,
	input  logic                                               csr_we_i,
	input  csr_pkg::csr_addr_e                                 csr_addr_i,
	input  logic [31:0]                                        csr_wdata_i,
	input  logic                                               tlb_wr_i,
	input  logic [mmu_pkg::PORT_NUM-1:0]                       req_valid_i,
	input  logic [mmu_pkg::PORT_NUM-1:0][mmu_pkg::VADDR_W-1:0] req_vaddr_i,
	input  mmu_pkg::access_e [mmu_pkg::PORT_NUM-1:0]           req_access_i,
	output logic [mmu_pkg::PORT_NUM-1:0]                       resp_valid_o,
	output logic [mmu_pkg::PORT_NUM-1:0][mmu_pkg::VADDR_W-1:0] resp_paddr_o,
	output logic [mmu_pkg::PORT_NUM-1:0][mmu_pkg::MAT_W-1:0]   resp_mat_o,
	output mmu_pkg::ecode_e [mmu_pkg::PORT_NUM-1:0]            resp_ecode_o,
	output logic                                               fault_o,
	output logic [mmu_pkg::VADDR_W-1:0]                        badv_o,
	output mmu_pkg::ecode_e                                    ecode_o
);

	import mmu_pkg::*;

	logic [PLV_W-1:0] csr_plv;
	logic csr_da;
	logic csr_pg;
	logic [MAT_W-1:0] csr_datf;
	logic [MAT_W-1:0] csr_datm;
	logic [31:0] csr_dmw0;
	logic [31:0] csr_dmw1;
	logic [ASID_W-1:0] csr_asid;
	logic [VPPN_W-1:0] csr_vppn;
	logic [31:0] csr_tlbelo0;
	logic [31:0] csr_tlbelo1;
	logic [TLB_IDX_W-1:0] csr_tlbidx;

	logic [TLB_ENTRIES-1:0] tlb_e;
	logic [TLB_ENTRIES-1:0] tlb_g;
	logic [TLB_ENTRIES-1:0][ASID_W-1:0] tlb_asid;
	logic [TLB_ENTRIES-1:0][VPPN_W-1:0] tlb_vppn;
	logic [TLB_ENTRIES-1:0][1:0][PPN_W-1:0] tlb_ppn;
	logic [TLB_ENTRIES-1:0][1:0] tlb_v;
	logic [TLB_ENTRIES-1:0][1:0] tlb_d;
	logic [TLB_ENTRIES-1:0][1:0][PLV_W-1:0] tlb_plv;
	logic [TLB_ENTRIES-1:0][1:0][MAT_W-1:0] tlb_mat;

	logic [PORT_NUM-1:0][VADDR_W-1:0] resp_vaddr;

	mmu_csr_regs csr_regs (
		.clk(clk), .reset_i(reset_i),
		.csr_we_i(csr_we_i), .csr_addr_i(csr_addr_i), .csr_wdata_i(csr_wdata_i),
		.plv_o(csr_plv), .da_o(csr_da), .pg_o(csr_pg),
		.datf_o(csr_datf), .datm_o(csr_datm),
		.dmw0_o(csr_dmw0), .dmw1_o(csr_dmw1),
		.asid_o(csr_asid), .tlbehi_vppn_o(csr_vppn),
		.tlbelo0_o(csr_tlbelo0), .tlbelo1_o(csr_tlbelo1), .tlbidx_o(csr_tlbidx)
	);

	tlb_array tlb (
		.clk(clk), .reset_i(reset_i), .tlb_wr_i(tlb_wr_i),
		.tlbidx_i(csr_tlbidx), .asid_i(csr_asid), .tlbehi_vppn_i(csr_vppn),
		.tlbelo0_i(csr_tlbelo0), .tlbelo1_i(csr_tlbelo1),
		.e_o(tlb_e), .g_o(tlb_g), .asid_o(tlb_asid), .vppn_o(tlb_vppn),
		.ppn_o(tlb_ppn), .v_o(tlb_v), .d_o(tlb_d), .plv_o(tlb_plv), .mat_o(tlb_mat)
	);

	// port 0 fetch, port 1 data
	for (genvar p = 0; p < PORT_NUM; p++) begin : g_lane
		mmu_lane lane (
			.clk(clk), .reset_i(reset_i),
			.req_valid_i(req_valid_i[p]), .req_vaddr_i(req_vaddr_i[p]),
			.req_access_i(req_access_i[p]),
			.plv_i(csr_plv), .da_i(csr_da), .pg_i(csr_pg),
			.datf_i(csr_datf), .datm_i(csr_datm),
			.dmw0_i(csr_dmw0), .dmw1_i(csr_dmw1), .asid_i(csr_asid),
			.tlb_e_i(tlb_e), .tlb_g_i(tlb_g), .tlb_asid_i(tlb_asid), .tlb_vppn_i(tlb_vppn),
			.tlb_ppn_i(tlb_ppn), .tlb_v_i(tlb_v), .tlb_d_i(tlb_d),
			.tlb_plv_i(tlb_plv), .tlb_mat_i(tlb_mat),
			.resp_valid_o(resp_valid_o[p]), .resp_paddr_o(resp_paddr_o[p]),
			.resp_mat_o(resp_mat_o[p]), .resp_ecode_o(resp_ecode_o[p]),
			.resp_vaddr_o(resp_vaddr[p])
		);
	end

	fault_recorder recorder (
		.clk(clk), .reset_i(reset_i),
		.resp_valid_i(resp_valid_o), .resp_ecode_i(resp_ecode_o),
		.resp_vaddr_i(resp_vaddr),
		.fault_o(fault_o), .badv_o(badv_o), .ecode_o(ecode_o)
	);

endmodule

`default_nettype wire

//--- verilog/fault_recorder.sv
`timescale 1ns/10ps
`default_nettype none

module fault_recorder (
	input  logic                                              clk,
	input  logic                                              reset_i,
	input  logic [mmu_pkg::PORT_NUM-1:0]                      resp_valid_i,
	input  mmu_pkg::ecode_e [mmu_pkg::PORT_NUM-1:0]           resp_ecode_i,
	input  logic [mmu_pkg::PORT_NUM-1:0][mmu_pkg::VADDR_W-1:0] resp_vaddr_i,
	output logic                                              fault_o,
	output logic [mmu_pkg::VADDR_W-1:0]                       badv_o,
	output mmu_pkg::ecode_e                                   ecode_o
);

	import mmu_pkg::*;

	logic any_fault;
	logic [VADDR_W-1:0] badv_d;
	ecode_e ecode_d;

	// higher port overwrites lower one
	always_comb begin
		any_fault = 1'b0;
		badv_d = badv_o;
		ecode_d = ecode_o;
		for (int p = 0; p < PORT_NUM; p++) begin
			if (resp_valid_i[p] && resp_ecode_i[p] != ECODE_NONE) begin
				any_fault = 1'b1;
				badv_d = resp_vaddr_i[p];
				ecode_d = resp_ecode_i[p];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			fault_o <= 1'b0;
			badv_o <= '0;
			ecode_o <= ECODE_NONE;
		end else begin
			fault_o <= any_fault;
			badv_o <= badv_d;
			ecode_o <= ecode_d;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mmu_lane.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_lane (
	input  logic                                                   clk,
	input  logic                                                   reset_i,
	input  logic                                                   req_valid_i,
	input  logic [mmu_pkg::VADDR_W-1:0]                            req_vaddr_i,
	input  mmu_pkg::access_e                                       req_access_i,
	input  logic [mmu_pkg::PLV_W-1:0]                              plv_i,
	input  logic                                                   da_i,
	input  logic                                                   pg_i,
	input  logic [mmu_pkg::MAT_W-1:0]                              datf_i,
	input  logic [mmu_pkg::MAT_W-1:0]                              datm_i,
	input  logic [31:0]                                            dmw0_i,
	input  logic [31:0]                                            dmw1_i,
	input  logic [mmu_pkg::ASID_W-1:0]                             asid_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0]                        tlb_e_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0]                        tlb_g_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][mmu_pkg::ASID_W-1:0]   tlb_asid_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][mmu_pkg::VPPN_W-1:0]   tlb_vppn_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][1:0][mmu_pkg::PPN_W-1:0] tlb_ppn_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][1:0]                   tlb_v_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][1:0]                   tlb_d_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][1:0][mmu_pkg::PLV_W-1:0] tlb_plv_i,
	input  logic [mmu_pkg::TLB_ENTRIES-1:0][1:0][mmu_pkg::MAT_W-1:0] tlb_mat_i,
	output logic                                                   resp_valid_o,
	output logic [mmu_pkg::VADDR_W-1:0]                            resp_paddr_o,
	output logic [mmu_pkg::MAT_W-1:0]                              resp_mat_o,
	output mmu_pkg::ecode_e                                        resp_ecode_o,
	output logic [mmu_pkg::VADDR_W-1:0]                            resp_vaddr_o
);

	import mmu_pkg::*;
	import csr_pkg::*;

	logic direct;
	logic [1:0][31:0] dmw;
	logic [1:0] dmw_hit;
	logic [31:0] dmw_sel;
	logic tlb_hit;
	logic [TLB_IDX_W-1:0] hit_idx;
	logic odd;
	logic [PPN_W-1:0] pg_ppn;
	logic pg_v;
	logic pg_d;
	logic [PLV_W-1:0] pg_plv;
	logic [MAT_W-1:0] pg_mat;
	logic [VADDR_W-1:0] paddr_d;
	logic [MAT_W-1:0] mat_d;
	ecode_e ecode_d;

	// da=0 with pg=0 is undefined, treated as direct
	assign direct = da_i | ~pg_i;
	assign dmw = {dmw1_i, dmw0_i};

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			dmw_hit[w] = ((dmw[w][DMW_PLV0] && plv_i == '0)
				|| (dmw[w][DMW_PLV3] && plv_i == '1))
				&& dmw[w][DMW_VSEG_LO +: DMW_SEG_W] == req_vaddr_i[VADDR_W-1 -: DMW_SEG_W];
		end
	end

	// dmw0 wins when both hit
	assign dmw_sel = dmw_hit[0] ? dmw0_i : dmw1_i;

	// lowest matching entry
	always_comb begin
		tlb_hit = 1'b0;
		hit_idx = '0;
		for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
			if (tlb_e_i[i] && tlb_vppn_i[i] == req_vaddr_i[VADDR_W-1 -: VPPN_W]
				&& (tlb_g_i[i] || tlb_asid_i[i] == asid_i)) begin
				tlb_hit = 1'b1;
				hit_idx = i[TLB_IDX_W-1:0];
			end
		end
	end

	assign odd = req_vaddr_i[PAGE_OFS_W];
	assign pg_ppn = tlb_ppn_i[hit_idx][odd];
	assign pg_v = tlb_v_i[hit_idx][odd];
	assign pg_d = tlb_d_i[hit_idx][odd];
	assign pg_plv = tlb_plv_i[hit_idx][odd];
	assign pg_mat = tlb_mat_i[hit_idx][odd];

	always_comb begin
		ecode_d = ECODE_NONE;
		if (direct) begin
			paddr_d = req_vaddr_i;
			mat_d = (req_access_i == ACC_FETCH) ? datf_i : datm_i;
		end else if (|dmw_hit) begin
			paddr_d = {dmw_sel[DMW_PSEG_LO +: DMW_SEG_W], req_vaddr_i[VADDR_W-DMW_SEG_W-1:0]};
			mat_d = dmw_sel[DMW_MAT_LO +: MAT_W];
		end else begin
			paddr_d = {pg_ppn, req_vaddr_i[PAGE_OFS_W-1:0]};
			mat_d = pg_mat;
			if (!tlb_hit) begin
				ecode_d = ECODE_TLBR;
			end else if (!pg_v) begin
				case (req_access_i)
					ACC_FETCH: ecode_d = ECODE_PIF;
					ACC_LOAD:  ecode_d = ECODE_PIL;
					default:   ecode_d = ECODE_PIS;
				endcase
			end else if (plv_i > pg_plv) begin
				ecode_d = ECODE_PPI;
			end else if (req_access_i == ACC_STORE && !pg_d) begin
				ecode_d = ECODE_PME;
			end
		end
		// faulting responses carry no address and no mat
		if (ecode_d != ECODE_NONE) begin
			paddr_d = '0;
			mat_d = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			resp_valid_o <= 1'b0;
		end else begin
			resp_valid_o <= req_valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid_i) begin
			resp_paddr_o <= paddr_d;
			resp_mat_o <= mat_d;
			resp_ecode_o <= ecode_d;
			resp_vaddr_o <= req_vaddr_i;
		end
	end

endmodule

`default_nettype wire

//--- verilog/tlb_array.sv
`timescale 1ns/10ps
`default_nettype none

module tlb_array (
	input  logic                                                   clk,
	input  logic                                                   reset_i,
	input  logic                                                   tlb_wr_i,
	input  logic [mmu_pkg::TLB_IDX_W-1:0]                          tlbidx_i,
	input  logic [mmu_pkg::ASID_W-1:0]                             asid_i,
	input  logic [mmu_pkg::VPPN_W-1:0]                             tlbehi_vppn_i,
	input  logic [31:0]                                            tlbelo0_i,
	input  logic [31:0]                                            tlbelo1_i,
	output logic [mmu_pkg::TLB_ENTRIES-1:0]                        e_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0]                        g_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][mmu_pkg::ASID_W-1:0]   asid_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][mmu_pkg::VPPN_W-1:0]   vppn_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][1:0][mmu_pkg::PPN_W-1:0] ppn_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][1:0]                   v_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][1:0]                   d_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][1:0][mmu_pkg::PLV_W-1:0] plv_o,
	output logic [mmu_pkg::TLB_ENTRIES-1:0][1:0][mmu_pkg::MAT_W-1:0] mat_o
);

	import mmu_pkg::*;
	import csr_pkg::*;

	// page 0 is the even page, page 1 the odd one
	logic [1:0][31:0] lo;

	assign lo = {tlbelo1_i, tlbelo0_i};

	always_ff @(posedge clk) begin
		if (reset_i) begin
			e_o <= '0;
		end else if (tlb_wr_i) begin
			e_o[tlbidx_i] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (tlb_wr_i) begin
			// an entry is global only if both halves say so
			g_o[tlbidx_i] <= tlbelo0_i[TLBELO_G] & tlbelo1_i[TLBELO_G];
			asid_o[tlbidx_i] <= asid_i;
			vppn_o[tlbidx_i] <= tlbehi_vppn_i;
			for (int pg = 0; pg < 2; pg++) begin
				ppn_o[tlbidx_i][pg] <= lo[pg][TLBELO_PPN_LO +: PPN_W];
				v_o[tlbidx_i][pg] <= lo[pg][TLBELO_V];
				d_o[tlbidx_i][pg] <= lo[pg][TLBELO_D];
				plv_o[tlbidx_i][pg] <= lo[pg][TLBELO_PLV_LO +: PLV_W];
				mat_o[tlbidx_i][pg] <= lo[pg][TLBELO_MAT_LO +: MAT_W];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/mmu_csr_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mmu_csr_regs (
	input  logic                                clk,
	input  logic                                reset_i,
	input  logic                                csr_we_i,
	input  csr_pkg::csr_addr_e                  csr_addr_i,
	input  logic [31:0]                         csr_wdata_i,
	output logic [mmu_pkg::PLV_W-1:0]           plv_o,
	output logic                                da_o,
	output logic                                pg_o,
	output logic [mmu_pkg::MAT_W-1:0]           datf_o,
	output logic [mmu_pkg::MAT_W-1:0]           datm_o,
	output logic [31:0]                         dmw0_o,
	output logic [31:0]                         dmw1_o,
	output logic [mmu_pkg::ASID_W-1:0]          asid_o,
	output logic [mmu_pkg::VPPN_W-1:0]          tlbehi_vppn_o,
	output logic [31:0]                         tlbelo0_o,
	output logic [31:0]                         tlbelo1_o,
	output logic [mmu_pkg::TLB_IDX_W-1:0]       tlbidx_o
);

	import mmu_pkg::*;
	import csr_pkg::*;

	// only implemented fields are kept, reserved bits stay zero
	always_ff @(posedge clk) begin
		if (reset_i) begin
			plv_o <= '0;
			da_o <= 1'b1;
			pg_o <= 1'b0;
			datf_o <= '0;
			datm_o <= '0;
			dmw0_o <= '0;
			dmw1_o <= '0;
			asid_o <= '0;
			tlbehi_vppn_o <= '0;
			tlbelo0_o <= '0;
			tlbelo1_o <= '0;
			tlbidx_o <= '0;
		end else if (csr_we_i) begin
			case (csr_addr_i)
				CSR_CRMD: begin
					plv_o <= csr_wdata_i[CRMD_PLV_LO +: PLV_W];
					da_o <= csr_wdata_i[CRMD_DA];
					pg_o <= csr_wdata_i[CRMD_PG];
					datf_o <= csr_wdata_i[CRMD_DATF_LO +: MAT_W];
					datm_o <= csr_wdata_i[CRMD_DATM_LO +: MAT_W];
				end
				CSR_ASID: begin
					asid_o <= csr_wdata_i[ASID_ASID_LO +: ASID_W];
				end
				CSR_TLBIDX: begin
					tlbidx_o <= csr_wdata_i[TLBIDX_INDEX_LO +: TLB_IDX_W];
				end
				CSR_TLBEHI: begin
					tlbehi_vppn_o <= csr_wdata_i[TLBEHI_VPPN_LO +: VPPN_W];
				end
				CSR_TLBELO0: begin
					tlbelo0_o <= csr_wdata_i & TLBELO_MASK;
				end
				CSR_TLBELO1: begin
					tlbelo1_o <= csr_wdata_i & TLBELO_MASK;
				end
				CSR_DMW0: begin
					dmw0_o <= csr_wdata_i & DMW_MASK;
				end
				CSR_DMW1: begin
					dmw1_o <= csr_wdata_i & DMW_MASK;
				end
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

	// low byte of the architectural csr number
	typedef enum logic [7:0] {
		CSR_CRMD    = 8'h00,
		CSR_TLBIDX  = 8'h10,
		CSR_TLBEHI  = 8'h11,
		CSR_TLBELO0 = 8'h12,
		CSR_TLBELO1 = 8'h13,
		CSR_ASID    = 8'h18,
		CSR_DMW0    = 8'h80,
		CSR_DMW1    = 8'h81
	} csr_addr_e;

	// crmd
	localparam int CRMD_PLV_LO = 0;
	localparam int CRMD_DA = 3;
	localparam int CRMD_PG = 4;
	localparam int CRMD_DATF_LO = 5;
	localparam int CRMD_DATM_LO = 7;

	// dmw0 / dmw1
	localparam int DMW_PLV0 = 0;
	localparam int DMW_PLV3 = 3;
	localparam int DMW_MAT_LO = 4;
	localparam int DMW_PSEG_LO = 25;
	localparam int DMW_VSEG_LO = 29;
	localparam int DMW_SEG_W = 3;

	// tlbelo0 / tlbelo1
	localparam int TLBELO_V = 0;
	localparam int TLBELO_D = 1;
	localparam int TLBELO_PLV_LO = 2;
	localparam int TLBELO_MAT_LO = 4;
	localparam int TLBELO_G = 6;
	localparam int TLBELO_PPN_LO = 8;

	localparam int TLBEHI_VPPN_LO = 13;
	localparam int TLBIDX_INDEX_LO = 0;
	localparam int ASID_ASID_LO = 0;

	localparam logic [31:0] DMW_MASK = (32'h1 << DMW_PLV0) | (32'h1 << DMW_PLV3)
		| (32'h3 << DMW_MAT_LO) | (32'h7 << DMW_PSEG_LO) | (32'h7 << DMW_VSEG_LO);
	localparam logic [31:0] TLBELO_MASK = (32'h1 << TLBELO_V) | (32'h1 << TLBELO_D)
		| (32'h3 << TLBELO_PLV_LO) | (32'h3 << TLBELO_MAT_LO) | (32'h1 << TLBELO_G)
		| (32'hfffff << TLBELO_PPN_LO);

endpackage

`default_nettype wire

//--- verilog/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	localparam int VADDR_W = 32;
	localparam int PORT_NUM = 2;

	localparam int TLB_ENTRIES = 8;
	localparam int TLB_IDX_W = 3;

	// 4 KB pages in even/odd pairs
	localparam int VPPN_W = 19;
	localparam int PPN_W = 20;
	localparam int PAGE_OFS_W = VADDR_W - VPPN_W - 1;

	localparam int ASID_W = 10;
	localparam int MAT_W = 2;
	localparam int PLV_W = 2;

	typedef enum logic [1:0] {
		ACC_FETCH = 2'd0,
		ACC_LOAD  = 2'd1,
		ACC_STORE = 2'd2
	} access_e;

	// local encoding, not the architectural ecode/esubcode
	typedef enum logic [2:0] {
		ECODE_NONE = 3'd0,
		ECODE_TLBR = 3'd1,
		ECODE_PIF  = 3'd2,
		ECODE_PIL  = 3'd3,
		ECODE_PIS  = 3'd4,
		ECODE_PME  = 3'd5,
		ECODE_PPI  = 3'd6
	} ecode_e;

endpackage

`default_nettype wire
